// ==== common/collision_pkg.sv ====
`default_nettype none

package collision_pkg;

    // Playfield is a 16 by 16 grid.
    localparam int coord_bits = 4;

    localparam int num_asteroids = 8;
    localparam int asteroid_index_bits = 3;

    localparam int num_shots = 4;
    localparam int shot_index_bits = 2;

    localparam int lives_init = 3;
    localparam int lives_bits = 2;

    typedef struct packed {
        logic [coord_bits-1:0] x;
        logic [coord_bits-1:0] y;
    } position_t;

    typedef struct packed {
        logic      loaded;
        logic      destroyed;
        position_t position;
    } asteroid_entry_t;

    typedef struct packed {
        logic      loaded;
        position_t position;
    } shot_entry_t;

    // Ship controller state codes, also seen on the debug port.
    localparam int ship_state_bits = 5;
    localparam logic [ship_state_bits-1:0] ship_initial        = 5'h00;
    localparam logic [ship_state_bits-1:0] ship_idle           = 5'h01;
    localparam logic [ship_state_bits-1:0] ship_reset_counter  = 5'h02;
    localparam logic [ship_state_bits-1:0] ship_compare        = 5'h03;
    localparam logic [ship_state_bits-1:0] ship_decrement      = 5'h04;
    localparam logic [ship_state_bits-1:0] ship_destroy_state  = 5'h05;
    localparam logic [ship_state_bits-1:0] ship_save           = 5'h06;
    localparam logic [ship_state_bits-1:0] ship_start_shot     = 5'h07;
    localparam logic [ship_state_bits-1:0] ship_wait_shot      = 5'h08;
    localparam logic [ship_state_bits-1:0] ship_count          = 5'h09;
    localparam logic [ship_state_bits-1:0] ship_finish         = 5'h0a;
    localparam logic [ship_state_bits-1:0] ship_settle         = 5'h0b;
    localparam logic [ship_state_bits-1:0] ship_error          = 5'h0f;

    // Shot unit states.
    localparam int shot_state_bits = 2;
    localparam logic [shot_state_bits-1:0] shot_idle   = 2'd0;
    localparam logic [shot_state_bits-1:0] shot_scan   = 2'd1;
    localparam logic [shot_state_bits-1:0] shot_finish = 2'd2;

endpackage

`default_nettype wire

// ==== asteroid_table/asteroid_table.sv ====
`default_nettype none

module asteroid_table import collision_pkg::*; (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           write,
    input  wire logic [asteroid_index_bits-1:0] write_index,
    input  wire asteroid_entry_t                write_entry,
    input  wire logic [asteroid_index_bits-1:0] ship_index,
    input  wire logic                           ship_destroy,
    input  wire logic [asteroid_index_bits-1:0] shot_index,
    input  wire logic                           shot_destroy,
    input  wire logic [asteroid_index_bits-1:0] render_index,
    output asteroid_entry_t                     ship_entry,
    output asteroid_entry_t                     shot_entry,
    output asteroid_entry_t                     render_entry
);

    asteroid_entry_t entries [num_asteroids];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_asteroids; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[write_index] <= write_entry;
        end else if (ship_destroy) begin
            entries[ship_index].destroyed <= 1'b1;
        end else if (shot_destroy) begin
            entries[shot_index].destroyed <= 1'b1;
        end
    end

    // Three independent combinational read ports.
    assign ship_entry   = entries[ship_index];
    assign shot_entry   = entries[shot_index];
    assign render_entry = entries[render_index];

    // Loader and both controllers never write in the same cycle.
    a_single_writer: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({write, ship_destroy, shot_destroy})
    );

    a_destroy_loaded: assert property (
        @(posedge clock) disable iff (reset)
        (ship_destroy -> entries[ship_index].loaded) &&
        (shot_destroy -> entries[shot_index].loaded)
    );

endmodule

`default_nettype wire

// ==== shot_collision/shot_table.sv ====
`default_nettype none

module shot_table import collision_pkg::*; (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       write,
    input  wire logic [shot_index_bits-1:0] write_index,
    input  wire shot_entry_t                write_entry,
    input  wire logic [shot_index_bits-1:0] scan_index,
    input  wire logic                       clear,
    input  wire logic [shot_index_bits-1:0] render_index,
    output shot_entry_t                     scan_entry,
    output shot_entry_t                     render_entry
);

    shot_entry_t entries [num_shots];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_shots; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[write_index] <= write_entry;
        end else if (clear) begin
            // Position is kept, only the shot is retired.
            entries[scan_index].loaded <= 1'b0;
        end
    end

    assign scan_entry   = entries[scan_index];
    assign render_entry = entries[render_index];

    a_write_clear_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(write && clear)
    );

endmodule

`default_nettype wire

// ==== shot_collision/shot_collision_unit.sv ====
`default_nettype none

module shot_collision_unit import collision_pkg::*; (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           pass_start,
    input  wire shot_entry_t                    shot_entry,
    input  wire asteroid_entry_t                asteroid_entry,
    output logic      [shot_index_bits-1:0]     shot_index,
    output logic      [asteroid_index_bits-1:0] asteroid_index,
    output logic                                shot_clear,
    output logic                                asteroid_destroy,
    output logic                                pass_done
);

    logic [shot_state_bits-1:0] state;
    logic                       shot_last;
    logic                       asteroid_last;
    logic                       asteroid_live;
    logic                       match;

    assign shot_last     = shot_index == shot_index_bits'(num_shots - 1);
    assign asteroid_last = asteroid_index == asteroid_index_bits'(num_asteroids - 1);
    assign asteroid_live = asteroid_entry.loaded && !asteroid_entry.destroyed;

    // One shot-asteroid comparison per scan cycle.
    assign match = state == shot_scan && shot_entry.loaded && asteroid_live &&
                   asteroid_entry.position == shot_entry.position;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= shot_idle;
            shot_index     <= '0;
            asteroid_index <= '0;
        end else begin
            case (state)
                shot_idle: begin
                    if (pass_start) begin
                        shot_index     <= '0;
                        asteroid_index <= '0;
                        state          <= shot_scan;
                    end
                end
                shot_scan: begin
                    // Dead shot, hit, or asteroid list exhausted: next shot.
                    if (!shot_entry.loaded || match || asteroid_last) begin
                        asteroid_index <= '0;
                        if (shot_last) begin
                            state <= shot_finish;
                        end else begin
                            shot_index <= shot_index + 1'b1;
                        end
                    end else begin
                        asteroid_index <= asteroid_index + 1'b1;
                    end
                end
                shot_finish: state <= shot_idle;
                default:     state <= shot_idle;
            endcase
        end
    end

    assign shot_clear       = match;
    assign asteroid_destroy = match;
    assign pass_done        = state == shot_finish;

    // The ship controller only starts a shot pass while this unit is idle.
    a_start_when_idle: assert property (
        @(posedge clock) disable iff (reset)
        pass_start |-> state == shot_idle
    );

endmodule

`default_nettype wire

// ==== source/lives_counter.sv ====
`default_nettype none

module lives_counter import collision_pkg::*; (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  lose_life,
    output logic      [lives_bits-1:0] lives,
    output logic                       spare_life
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lives <= lives_bits'(lives_init);
        end else if (lose_life && lives != '0) begin
            lives <= lives - 1'b1;
        end
    end

    // A decrement from here still leaves the ship alive.
    assign spare_life = lives > lives_bits'(1);

endmodule

`default_nettype wire

// ==== source/ship_collision_control.sv ====
`default_nettype none

module ship_collision_control import collision_pkg::*; (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           start,
    input  wire position_t                      ship_position,
    input  wire asteroid_entry_t                scan_entry,
    input  wire logic                           spare_life,
    input  wire logic                           shot_pass_done,
    output logic      [asteroid_index_bits-1:0] scan_index,
    output logic                                lose_life,
    output logic                                destroy,
    output logic                                shot_pass_start,
    output logic                                done,
    output logic      [ship_state_bits-1:0]     state_debug
);

    logic [ship_state_bits-1:0]     state;
    logic [ship_state_bits-1:0]     next_state;
    logic [asteroid_index_bits-1:0] counter;
    logic                           hit;
    logic                           last;

    // Live asteroid sitting on the ship.
    assign hit  = scan_entry.loaded && !scan_entry.destroyed &&
                  scan_entry.position == ship_position;
    assign last = counter == asteroid_index_bits'(num_asteroids - 1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ship_initial;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ship_initial:       next_state = ship_idle;
            ship_idle:          next_state = start ? ship_reset_counter : ship_idle;
            ship_reset_counter: next_state = ship_compare;
            ship_compare: begin
                if (hit) begin
                    next_state = ship_decrement;
                end else if (last) begin
                    next_state = ship_start_shot;
                end else begin
                    next_state = ship_count;
                end
            end
            // Last life gone, the shot pass is skipped.
            ship_decrement:     next_state = spare_life ? ship_destroy_state : ship_finish;
            ship_destroy_state: next_state = ship_save;
            ship_save:          next_state = last ? ship_start_shot : ship_count;
            ship_start_shot:    next_state = ship_wait_shot;
            ship_wait_shot:     next_state = shot_pass_done ? ship_finish : ship_wait_shot;
            ship_count:         next_state = ship_settle;
            ship_settle:        next_state = ship_compare;
            ship_finish:        next_state = ship_idle;
            default:            next_state = ship_initial;
        endcase
    end

    // Asteroid scan counter.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counter <= '0;
        end else if (state == ship_reset_counter) begin
            counter <= '0;
        end else if (state == ship_count) begin
            counter <= counter + 1'b1;
        end
    end

    assign scan_index = counter;

    // Moore outputs.
    assign lose_life       = state == ship_decrement;
    assign destroy         = state == ship_save;
    assign shot_pass_start = state == ship_start_shot;
    assign done            = state == ship_finish;

    always_comb begin
        case (state)
            ship_initial, ship_idle, ship_reset_counter, ship_compare,
            ship_decrement, ship_destroy_state, ship_save, ship_start_shot,
            ship_wait_shot, ship_count, ship_finish, ship_settle: begin
                state_debug = state;
            end
            default: state_debug = ship_error;
        endcase
    end

    // The asteroid that costs the life still sits on the ship.
    a_lose_life_on_hit: assert property (
        @(posedge clock) disable iff (reset)
        lose_life |-> hit
    );

endmodule

`default_nettype wire

// ==== source/collision_top.sv ====
`default_nettype none

module collision_top import collision_pkg::*; (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           asteroid_write,
    input  wire logic [asteroid_index_bits-1:0] asteroid_write_index,
    input  wire asteroid_entry_t                asteroid_write_entry,
    input  wire logic                           shot_write,
    input  wire logic [shot_index_bits-1:0]     shot_write_index,
    input  wire shot_entry_t                    shot_write_entry,
    input  wire position_t                      ship_position,
    input  wire logic                           start,
    input  wire logic [asteroid_index_bits-1:0] render_asteroid_index,
    input  wire logic [shot_index_bits-1:0]     render_shot_index,
    output asteroid_entry_t                     render_asteroid,
    output shot_entry_t                         render_shot,
    output logic                                done,
    output logic      [lives_bits-1:0]          lives,
    output logic      [ship_state_bits-1:0]     state_debug
);

    logic [asteroid_index_bits-1:0] ship_scan_index;
    asteroid_entry_t                ship_scan_entry;
    logic                           ship_destroy;
    logic                           lose_life;
    logic                           spare_life;
    logic                           shot_pass_start;
    logic                           shot_pass_done;
    logic [shot_index_bits-1:0]     shot_scan_index;
    logic [asteroid_index_bits-1:0] asteroid_scan_index;
    shot_entry_t                    shot_scan_entry;
    asteroid_entry_t                asteroid_scan_entry;
    logic                           shot_destroy;
    logic                           shot_clear;

    asteroid_table asteroid_table0 (
        .clock        (clock),
        .reset        (reset),
        .write        (asteroid_write),
        .write_index  (asteroid_write_index),
        .write_entry  (asteroid_write_entry),
        .ship_index   (ship_scan_index),
        .ship_destroy (ship_destroy),
        .shot_index   (asteroid_scan_index),
        .shot_destroy (shot_destroy),
        .render_index (render_asteroid_index),
        .ship_entry   (ship_scan_entry),
        .shot_entry   (asteroid_scan_entry),
        .render_entry (render_asteroid)
    );

    shot_table shot_table0 (
        .clock        (clock),
        .reset        (reset),
        .write        (shot_write),
        .write_index  (shot_write_index),
        .write_entry  (shot_write_entry),
        .scan_index   (shot_scan_index),
        .clear        (shot_clear),
        .render_index (render_shot_index),
        .scan_entry   (shot_scan_entry),
        .render_entry (render_shot)
    );

    lives_counter lives_counter0 (
        .clock      (clock),
        .reset      (reset),
        .lose_life  (lose_life),
        .lives      (lives),
        .spare_life (spare_life)
    );

    ship_collision_control ship_control0 (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .ship_position   (ship_position),
        .scan_entry      (ship_scan_entry),
        .spare_life      (spare_life),
        .shot_pass_done  (shot_pass_done),
        .scan_index      (ship_scan_index),
        .lose_life       (lose_life),
        .destroy         (ship_destroy),
        .shot_pass_start (shot_pass_start),
        .done            (done),
        .state_debug     (state_debug)
    );

    shot_collision_unit shot_unit0 (
        .clock            (clock),
        .reset            (reset),
        .pass_start       (shot_pass_start),
        .shot_entry       (shot_scan_entry),
        .asteroid_entry   (asteroid_scan_entry),
        .shot_index       (shot_scan_index),
        .asteroid_index   (asteroid_scan_index),
        .shot_clear       (shot_clear),
        .asteroid_destroy (shot_destroy),
        .pass_done        (shot_pass_done)
    );

endmodule

`default_nettype wire

// ==== sim/collision_tb.sv ====
`default_nettype none

module collision_tb import collision_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Worst-case pass with margin, and the whole run bounded by 30 of them.
    localparam int pass_limit     = 2 * (16 + 3 * num_asteroids + num_asteroids * num_shots);
    localparam int timeout_cycles = 30 * pass_limit;

    logic                           clock;
    logic                           reset;
    logic                           asteroid_write;
    logic [asteroid_index_bits-1:0] asteroid_write_index;
    asteroid_entry_t                asteroid_write_entry;
    logic                           shot_write;
    logic [shot_index_bits-1:0]     shot_write_index;
    shot_entry_t                    shot_write_entry;
    position_t                      ship_position;
    logic                           start;
    logic [asteroid_index_bits-1:0] render_asteroid_index;
    logic [shot_index_bits-1:0]     render_shot_index;
    asteroid_entry_t                render_asteroid;
    shot_entry_t                    render_shot;
    logic                           done;
    logic [lives_bits-1:0]          lives;
    logic [ship_state_bits-1:0]     state_debug;

    // Reference copies of both tables and the lives count.
    asteroid_entry_t model_asteroids [num_asteroids];
    shot_entry_t     model_shots [num_shots];
    int              model_lives;
    position_t       ship_target;

    logic [15:0] lfsr;
    int          cycle_count;

    collision_top dut0 (
        .clock                 (clock),
        .reset                 (reset),
        .asteroid_write        (asteroid_write),
        .asteroid_write_index  (asteroid_write_index),
        .asteroid_write_entry  (asteroid_write_entry),
        .shot_write            (shot_write),
        .shot_write_index      (shot_write_index),
        .shot_write_entry      (shot_write_entry),
        .ship_position         (ship_position),
        .start                 (start),
        .render_asteroid_index (render_asteroid_index),
        .render_shot_index     (render_shot_index),
        .render_asteroid       (render_asteroid),
        .render_shot           (render_shot),
        .done                  (done),
        .lives                 (lives),
        .state_debug           (state_debug)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Taps 16, 14, 13, 11.
    function automatic logic lfsr_step();
        logic feedback;
        feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // Small position pool so that collisions happen often.
    function automatic position_t pick_position(input position_t ship);
        position_t p;
        if (random_bits(2) == 0) begin
            p = ship;
        end else begin
            p.x = coord_bits'(random_bits(2));
            p.y = coord_bits'(random_bits(2));
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < num_asteroids; i++) begin
            model_asteroids[i] = '0;
        end
        for (int s = 0; s < num_shots; s++) begin
            model_shots[s] = '0;
        end
        model_lives = lives_init;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        clear_model();
        repeat (2) @(posedge clock);
    endtask

    // Ship pass, then shot pass if the ship survived.
    task automatic apply_pass_rules();
        logic ended;
        logic removed;
        ended = 1'b0;
        for (int i = 0; i < num_asteroids; i++) begin
            if (!ended && model_asteroids[i].loaded && !model_asteroids[i].destroyed &&
                model_asteroids[i].position == ship_target) begin
                if (model_lives > 1) begin
                    model_lives--;
                    model_asteroids[i].destroyed = 1'b1;
                end else begin
                    model_lives = 0;
                    ended = 1'b1;
                end
            end
        end
        for (int s = 0; s < num_shots; s++) begin
            removed = 1'b0;
            for (int a = 0; a < num_asteroids; a++) begin
                if (!ended && !removed && model_shots[s].loaded &&
                    model_asteroids[a].loaded && !model_asteroids[a].destroyed &&
                    model_asteroids[a].position == model_shots[s].position) begin
                    model_asteroids[a].destroyed = 1'b1;
                    model_shots[s].loaded = 1'b0;
                    removed = 1'b1;
                end
            end
        end
    endtask

    // Rewrites about half of the entries, old ones stay as they were.
    task automatic load_tables();
        asteroid_entry_t a;
        shot_entry_t     s;
        for (int i = 0; i < num_asteroids; i++) begin
            if (random_bits(1) == 1) begin
                a.loaded    = random_bits(3) != 0;
                a.destroyed = random_bits(3) == 0;
                a.position  = pick_position(ship_target);
                @(posedge clock);
                asteroid_write       <= 1'b1;
                asteroid_write_index <= asteroid_index_bits'(i);
                asteroid_write_entry <= a;
                model_asteroids[i] = a;
            end
        end
        @(posedge clock);
        asteroid_write <= 1'b0;
        for (int i = 0; i < num_shots; i++) begin
            if (random_bits(1) == 1) begin
                s.loaded   = random_bits(2) != 0;
                s.position = pick_position(ship_target);
                @(posedge clock);
                shot_write       <= 1'b1;
                shot_write_index <= shot_index_bits'(i);
                shot_write_entry <= s;
                model_shots[i] = s;
            end
        end
        @(posedge clock);
        shot_write <= 1'b0;
    endtask

    task automatic run_pass(input logic extra_start);
        int waited;
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        // Second start lands while the ship scan is still busy.
        if (extra_start) begin
            repeat (3) @(posedge clock);
            start <= 1'b1;
            @(posedge clock);
            start <= 1'b0;
        end
        waited = 0;
        @(negedge clock);
        while (!done) begin
            assert (waited < pass_limit) else begin
                $display("No done pulse within %0d cycles of start", pass_limit);
                $display("STATUS: FAIL");
                $fatal(1, "Pass timeout");
            end
            @(negedge clock);
            waited++;
        end
        // Done comes from the finish state.
        check_value("state_debug", 32'(state_debug), 32'(ship_finish));
    endtask

    // Reads every entry back; done must stay low meanwhile.
    task automatic sweep_render();
        for (int i = 0; i < num_asteroids; i++) begin
            @(posedge clock);
            render_asteroid_index <= asteroid_index_bits'(i);
            @(negedge clock);
            check_value($sformatf("render_asteroid[%0d]", i), 32'(render_asteroid),
                        32'(model_asteroids[i]));
            check_value("done", 32'(done), 32'(0));
        end
        for (int i = 0; i < num_shots; i++) begin
            @(posedge clock);
            render_shot_index <= shot_index_bits'(i);
            @(negedge clock);
            check_value($sformatf("render_shot[%0d]", i), 32'(render_shot),
                        32'(model_shots[i]));
            check_value("done", 32'(done), 32'(0));
        end
        check_value("lives", 32'(lives), 32'(model_lives));
        check_value("state_debug", 32'(state_debug), 32'(ship_idle));
    endtask

    initial begin
        lfsr                  = 16'd60;
        reset                 = 1'b1;
        start                 = 1'b0;
        asteroid_write        = 1'b0;
        asteroid_write_index  = '0;
        asteroid_write_entry  = '0;
        shot_write            = 1'b0;
        shot_write_index      = '0;
        shot_write_entry      = '0;
        ship_position         = '0;
        render_asteroid_index = '0;
        render_shot_index     = '0;
        ship_target           = '0;
        // Each round starts from reset with full lives.
        for (int round = 0; round < 3; round++) begin
            apply_reset();
            sweep_render();
            for (int pass = 0; pass < 7; pass++) begin
                ship_target.x = coord_bits'(random_bits(2));
                ship_target.y = coord_bits'(random_bits(2));
                @(posedge clock);
                ship_position <= ship_target;
                load_tables();
                run_pass(round == 2 && pass == 0);
                apply_pass_rules();
                sweep_render();
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Simulation ran past %0d cycles", timeout_cycles);
        $display("STATUS: FAIL");
        $fatal(1, "Global timeout");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/collision_pkg.sv
asteroid_table/asteroid_table.sv
shot_collision/shot_table.sv
shot_collision/shot_collision_unit.sv
source/lives_counter.sv
source/ship_collision_control.sv
source/collision_top.sv
sim/collision_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module collision_tb -o collision_sim &&
./obj_dir/collision_sim || exit 1
